// ==== src/isa_pkg.sv ====
package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [15:0] imm16_t;

  // Primary opcodes in inst[31:26]
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // R-type function codes in inst[5:0]
  localparam logic [5:0] fn_addu  = 6'h21;
  localparam logic [5:0] fn_subu  = 6'h23;
  localparam logic [5:0] fn_and   = 6'h24;
  localparam logic [5:0] fn_or    = 6'h25;
  localparam logic [5:0] fn_xor   = 6'h26;
  localparam logic [5:0] fn_slt   = 6'h2a;
  localparam logic [5:0] fn_sltu  = 6'h2b;

  // Bubble that decodes as no operation
  localparam word_t nop_word = 32'h0000_0000;

endpackage

// ==== src/pipe_pkg.sv ====
package pipe_pkg;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu
  } alu_op_t;

  typedef enum logic [1:0] {
    br_none,
    br_eq,
    br_ne
  } branch_cond_t;

  // Operand source in execute
  typedef enum logic [1:0] {
    fwd_reg,
    fwd_ex_mem,
    fwd_mem_wb
  } fwd_sel_t;

endpackage

// ==== src/pipe_ifaces.sv ====
`timescale 1ns/100ps

interface id_ex_if
  import isa_pkg::*, pipe_pkg::*;
();
  word_t        a;
  word_t        b;
  reg_idx_t     a_reg;
  reg_idx_t     b_reg;
  word_t        imm;
  logic         imm_valid;
  alu_op_t      alu_op;
  branch_cond_t branch_cond;
  logic         load_inst;
  logic         store_inst;
  reg_idx_t     dest_reg;
  logic         dest_valid;
  word_t        pc_plus_4;

  modport dec (
    output a, b, a_reg, b_reg, imm, imm_valid, alu_op, branch_cond,
           load_inst, store_inst, dest_reg, dest_valid, pc_plus_4
  );
  modport exe (
    input  a, b, a_reg, b_reg, imm, imm_valid, alu_op, branch_cond,
           load_inst, store_inst, dest_reg, dest_valid, pc_plus_4
  );
endinterface

interface ex_mem_if
  import isa_pkg::*;
();
  word_t    result;
  word_t    store_data;
  reg_idx_t dest_reg;
  logic     dest_valid;
  logic     load_inst;
  logic     store_inst;

  modport exe (output result, store_data, dest_reg, dest_valid, load_inst, store_inst);
  modport mem (input  result, store_data, dest_reg, dest_valid, load_inst, store_inst);
endinterface

// MEM/WB result seen by the forwarding logic
interface fwd_if
  import isa_pkg::*;
();
  word_t    result;
  reg_idx_t dest_reg;
  logic     dest_valid;

  modport mem (output result, dest_reg, dest_valid);
  modport exe (input  result, dest_reg, dest_valid);
endinterface

// ==== src/ifetch.sv ====
`timescale 1ns/100ps

module ifetch
  import isa_pkg::*;
#(
  parameter int    addr_width = 32,
  parameter word_t reset_pc   = '0
)(
  input  logic                  clock,
  input  logic                  arst_n_i,
  input  word_t                 icache_data_i,
  input  logic                  icache_waitrequest_i,
  input  logic                  stall_i,
  input  logic                  redirect_i,
  input  word_t                 new_pc_i,
  output logic [addr_width-1:0] icache_addr_o,
  output logic                  icache_rd_o,
  output word_t                 inst_word_o,
  output word_t                 pc_plus_4_o
);

  word_t pc;
  logic  accept;

  assign icache_rd_o   = ~stall_i;
  assign icache_addr_o = pc[addr_width-1:0];
  assign accept        = icache_rd_o & ~icache_waitrequest_i;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc          <= reset_pc;
      inst_word_o <= nop_word;
    end else if (redirect_i) begin
      // Word arriving this cycle is on the wrong path
      pc          <= new_pc_i;
      inst_word_o <= nop_word;
    end else if (accept) begin
      pc          <= pc + 32'd4;
      inst_word_o <= icache_data_i;
    end else if (!stall_i) begin
      inst_word_o <= nop_word;
    end
  end

  always_ff @(posedge clock) begin
    if (accept && !redirect_i) begin
      pc_plus_4_o <= pc + 32'd4;
    end
  end

endmodule

// ==== src/idec.sv ====
`timescale 1ns/100ps

module idec
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n_i,
  input  word_t    inst_word_i,
  input  word_t    pc_plus_4_i,
  input  word_t    rfile_rd_data1_i,
  input  word_t    rfile_rd_data2_i,
  input  logic     mem_stall_i,
  input  logic     flush_i,
  output reg_idx_t rfile_rd_addr1_o,
  output reg_idx_t rfile_rd_addr2_o,
  output logic     id_stall_o,
  id_ex_if.dec     id_ex
);

  logic [5:0]   opcode;
  logic [5:0]   funct;
  reg_idx_t     rs;
  reg_idx_t     rt;
  reg_idx_t     rd;
  imm16_t       imm16;
  word_t        imm;
  logic         imm_valid;
  alu_op_t      alu_op;
  branch_cond_t branch_cond;
  logic         load_inst;
  logic         store_inst;
  reg_idx_t     dest_reg;
  logic         dest_valid;
  logic         b_used;
  logic         bubble;

  assign opcode = inst_word_i[31:26];
  assign rs     = inst_word_i[25:21];
  assign rt     = inst_word_i[20:16];
  assign rd     = inst_word_i[15:11];
  assign funct  = inst_word_i[5:0];
  assign imm16  = inst_word_i[15:0];

  assign rfile_rd_addr1_o = rs;
  assign rfile_rd_addr2_o = rt;

  always_comb begin
    alu_op      = alu_add;
    branch_cond = br_none;
    imm         = {{16{imm16[15]}}, imm16};
    imm_valid   = 1'b0;
    load_inst   = 1'b0;
    store_inst  = 1'b0;
    dest_reg    = rd;
    dest_valid  = 1'b0;
    b_used      = 1'b0;
    case (opcode)
      op_rtype: begin
        dest_valid = 1'b1;
        b_used     = 1'b1;
        case (funct)
          fn_addu: alu_op = alu_add;
          fn_subu: alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_xor:  alu_op = alu_xor;
          fn_slt:  alu_op = alu_slt;
          fn_sltu: alu_op = alu_sltu;
          default: dest_valid = 1'b0;
        endcase
      end
      op_addiu: begin
        imm_valid  = 1'b1;
        dest_reg   = rt;
        dest_valid = 1'b1;
      end
      op_ori: begin
        alu_op     = alu_or;
        imm        = {16'h0000, imm16};
        imm_valid  = 1'b1;
        dest_reg   = rt;
        dest_valid = 1'b1;
      end
      op_lw: begin
        imm_valid  = 1'b1;
        load_inst  = 1'b1;
        dest_reg   = rt;
        dest_valid = 1'b1;
      end
      op_sw: begin
        imm_valid  = 1'b1;
        store_inst = 1'b1;
        b_used     = 1'b1;
      end
      op_beq: begin
        branch_cond = br_eq;
        b_used      = 1'b1;
      end
      op_bne: begin
        branch_cond = br_ne;
        b_used      = 1'b1;
      end
      default: ;
    endcase
    // r0 is never written
    if (dest_reg == 5'd0) begin
      dest_valid = 1'b0;
    end
  end

  // Load in ID/EX feeding this instruction
  assign id_stall_o = id_ex.load_inst && id_ex.dest_valid &&
                      (id_ex.dest_reg == rs || (b_used && id_ex.dest_reg == rt));

  assign bubble = flush_i | id_stall_o;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex.dest_valid  <= 1'b0;
      id_ex.load_inst   <= 1'b0;
      id_ex.store_inst  <= 1'b0;
      id_ex.branch_cond <= br_none;
    end else if (!mem_stall_i) begin
      id_ex.dest_valid  <= dest_valid & ~bubble;
      id_ex.load_inst   <= load_inst & ~bubble;
      id_ex.store_inst  <= store_inst & ~bubble;
      id_ex.branch_cond <= bubble ? br_none : branch_cond;
    end
  end

  always_ff @(posedge clock) begin
    if (!mem_stall_i) begin
      id_ex.a         <= rfile_rd_data1_i;
      id_ex.b         <= rfile_rd_data2_i;
      id_ex.a_reg     <= rs;
      id_ex.b_reg     <= rt;
      id_ex.imm       <= imm;
      id_ex.imm_valid <= imm_valid;
      id_ex.alu_op    <= alu_op;
      id_ex.dest_reg  <= dest_reg;
      id_ex.pc_plus_4 <= pc_plus_4_i;
    end
  end

endmodule

// ==== src/ex.sv ====
`timescale 1ns/100ps

module ex
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter int addr_width = 32
)(
  input  logic  clock,
  input  logic  arst_n_i,
  input  logic  mem_stall_i,
  output logic  redirect_o,
  output word_t new_pc_o,
  id_ex_if.exe  id_ex,
  fwd_if.exe    fwd,
  ex_mem_if.exe ex_mem
);

  localparam word_t addr_mask = word_t'((64'd1 << addr_width) - 64'd1);

  word_t    a_hold;
  word_t    b_hold;
  logic     hold_valid;
  word_t    a_reg_val;
  word_t    b_reg_val;
  fwd_sel_t a_sel;
  fwd_sel_t b_sel;
  word_t    op_a;
  word_t    op_b;
  word_t    alu_b;
  word_t    alu_res;
  logic     taken;

  // Youngest valid producer wins
  function automatic fwd_sel_t fwd_pick(reg_idx_t src, reg_idx_t exm_reg, logic exm_valid,
                                        reg_idx_t wb_reg, logic wb_valid);
    fwd_sel_t sel;
    sel = fwd_reg;
    if (src != 5'd0) begin
      if (exm_valid && exm_reg == src)
        sel = fwd_ex_mem;
      else if (wb_valid && wb_reg == src)
        sel = fwd_mem_wb;
    end
    return sel;
  endfunction

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t exm_val,
                                    word_t wb_val);
    case (sel)
      fwd_ex_mem: return exm_val;
      fwd_mem_wb: return wb_val;
      default:    return reg_val;
    endcase
  endfunction

  // MEM/WB empties during a memory stall, so keep what was forwarded
  assign a_reg_val = hold_valid ? a_hold : id_ex.a;
  assign b_reg_val = hold_valid ? b_hold : id_ex.b;

  assign a_sel = fwd_pick(id_ex.a_reg, ex_mem.dest_reg, ex_mem.dest_valid,
                          fwd.dest_reg, fwd.dest_valid);
  assign b_sel = fwd_pick(id_ex.b_reg, ex_mem.dest_reg, ex_mem.dest_valid,
                          fwd.dest_reg, fwd.dest_valid);
  assign op_a  = fwd_mux(a_sel, a_reg_val, ex_mem.result, fwd.result);
  assign op_b  = fwd_mux(b_sel, b_reg_val, ex_mem.result, fwd.result);
  assign alu_b = id_ex.imm_valid ? id_ex.imm : op_b;

  always_comb begin
    case (id_ex.alu_op)
      alu_sub:  alu_res = op_a - alu_b;
      alu_and:  alu_res = op_a & alu_b;
      alu_or:   alu_res = op_a | alu_b;
      alu_xor:  alu_res = op_a ^ alu_b;
      alu_slt:  alu_res = word_t'($signed(op_a) < $signed(alu_b));
      alu_sltu: alu_res = word_t'(op_a < alu_b);
      default:  alu_res = op_a + alu_b;
    endcase
  end

  always_comb begin
    case (id_ex.branch_cond)
      br_eq:   taken = (op_a == op_b);
      br_ne:   taken = (op_a != op_b);
      default: taken = 1'b0;
    endcase
  end

  assign redirect_o = taken & ~mem_stall_i;
  assign new_pc_o   = id_ex.pc_plus_4 + {id_ex.imm[29:0], 2'b00};

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_valid        <= 1'b0;
      ex_mem.dest_valid <= 1'b0;
      ex_mem.load_inst  <= 1'b0;
      ex_mem.store_inst <= 1'b0;
    end else begin
      hold_valid <= mem_stall_i;
      if (!mem_stall_i) begin
        ex_mem.dest_valid <= id_ex.dest_valid;
        ex_mem.load_inst  <= id_ex.load_inst;
        ex_mem.store_inst <= id_ex.store_inst;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_stall_i) begin
      a_hold <= op_a;
      b_hold <= op_b;
    end else begin
      ex_mem.result     <= (id_ex.load_inst | id_ex.store_inst) ? (alu_res & addr_mask)
                                                                : alu_res;
      ex_mem.store_data <= op_b;
      ex_mem.dest_reg   <= id_ex.dest_reg;
    end
  end

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage
  import isa_pkg::*;
#(
  parameter int addr_width = 32
)(
  input  logic                  clock,
  input  logic                  arst_n_i,
  input  word_t                 dcache_data_i,
  input  logic                  dcache_waitrequest_i,
  output logic [addr_width-1:0] dcache_addr_o,
  output logic                  dcache_rd_o,
  output logic                  dcache_wr_o,
  output word_t                 dcache_wr_data_o,
  output logic                  mem_stall_o,
  output reg_idx_t              rfile_wr_addr1_o,
  output logic                  rfile_wr_enable1_o,
  output word_t                 rfile_wr_data1_o,
  ex_mem_if.mem                 ex_mem,
  fwd_if.mem                    fwd
);

  word_t    wb_result;
  reg_idx_t wb_dest_reg;
  logic     wb_dest_valid;

  // Strobes held until waitrequest drops
  assign dcache_rd_o      = ex_mem.load_inst;
  assign dcache_wr_o      = ex_mem.store_inst;
  assign dcache_addr_o    = ex_mem.result[addr_width-1:0];
  assign dcache_wr_data_o = ex_mem.store_data;
  assign mem_stall_o      = (ex_mem.load_inst | ex_mem.store_inst) & dcache_waitrequest_i;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_dest_valid <= 1'b0;
    end else begin
      wb_dest_valid <= ex_mem.dest_valid & ~mem_stall_o;
    end
  end

  always_ff @(posedge clock) begin
    wb_result   <= ex_mem.load_inst ? dcache_data_i : ex_mem.result;
    wb_dest_reg <= ex_mem.dest_reg;
  end

  assign rfile_wr_addr1_o   = wb_dest_reg;
  assign rfile_wr_enable1_o = wb_dest_valid;
  assign rfile_wr_data1_o   = wb_result;

  assign fwd.result     = wb_result;
  assign fwd.dest_reg   = wb_dest_reg;
  assign fwd.dest_valid = wb_dest_valid;

endmodule

// ==== src/pipeline.sv ====
`timescale 1ns/100ps

module pipeline
  import isa_pkg::*;
#(
  parameter int    addr_width = 32,
  parameter word_t reset_pc   = '0
)(
  input  logic                  clock,
  input  logic                  arst_n_i,

  output logic [addr_width-1:0] icache_addr_o,
  output logic                  icache_rd_o,
  input  word_t                 icache_data_i,
  input  logic                  icache_waitrequest_i,

  output reg_idx_t              rfile_rd_addr1_o,
  output reg_idx_t              rfile_rd_addr2_o,
  input  word_t                 rfile_rd_data1_i,
  input  word_t                 rfile_rd_data2_i,

  output logic [addr_width-1:0] dcache_addr_o,
  output logic                  dcache_rd_o,
  output logic                  dcache_wr_o,
  output word_t                 dcache_wr_data_o,
  output logic [3:0]            dcache_wr_be_o,
  input  word_t                 dcache_data_i,
  input  logic                  dcache_waitrequest_i,

  output reg_idx_t              rfile_wr_addr1_o,
  output logic                  rfile_wr_enable1_o,
  output word_t                 rfile_wr_data1_o
);

  logic  mem_stall;
  logic  id_stall;
  logic  if_stall;
  logic  redirect;
  word_t new_pc;
  word_t if_inst_word;
  word_t if_pc_plus_4;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();
  fwd_if    fwd ();

  assign if_stall       = mem_stall | id_stall;
  // Word accesses only
  assign dcache_wr_be_o = 4'hf;

  ifetch #(
    .addr_width           (addr_width),
    .reset_pc             (reset_pc)
  ) ifetch_i (
    .clock                (clock),
    .arst_n_i             (arst_n_i),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .stall_i              (if_stall),
    .redirect_i           (redirect),
    .new_pc_i             (new_pc),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .inst_word_o          (if_inst_word),
    .pc_plus_4_o          (if_pc_plus_4)
  );

  idec idec_i (
    .clock                (clock),
    .arst_n_i             (arst_n_i),
    .inst_word_i          (if_inst_word),
    .pc_plus_4_i          (if_pc_plus_4),
    .rfile_rd_data1_i     (rfile_rd_data1_i),
    .rfile_rd_data2_i     (rfile_rd_data2_i),
    .mem_stall_i          (mem_stall),
    .flush_i              (redirect),
    .rfile_rd_addr1_o     (rfile_rd_addr1_o),
    .rfile_rd_addr2_o     (rfile_rd_addr2_o),
    .id_stall_o           (id_stall),
    .id_ex                (id_ex)
  );

  ex #(
    .addr_width           (addr_width)
  ) ex_i (
    .clock                (clock),
    .arst_n_i             (arst_n_i),
    .mem_stall_i          (mem_stall),
    .redirect_o           (redirect),
    .new_pc_o             (new_pc),
    .id_ex                (id_ex),
    .fwd                  (fwd),
    .ex_mem               (ex_mem)
  );

  mem_stage #(
    .addr_width           (addr_width)
  ) mem_stage_i (
    .clock                (clock),
    .arst_n_i             (arst_n_i),
    .dcache_data_i        (dcache_data_i),
    .dcache_waitrequest_i (dcache_waitrequest_i),
    .dcache_addr_o        (dcache_addr_o),
    .dcache_rd_o          (dcache_rd_o),
    .dcache_wr_o          (dcache_wr_o),
    .dcache_wr_data_o     (dcache_wr_data_o),
    .mem_stall_o          (mem_stall),
    .rfile_wr_addr1_o     (rfile_wr_addr1_o),
    .rfile_wr_enable1_o   (rfile_wr_enable1_o),
    .rfile_wr_data1_o     (rfile_wr_data1_o),
    .ex_mem               (ex_mem),
    .fwd                  (fwd)
  );

endmodule

// ==== testbench/tb_models.sv ====
`timescale 1ns/100ps

// Instruction memory of 64 words with combinational read
module imem_model
  import isa_pkg::*;
(
  input  word_t addr_i,
  output word_t data_o
);

  word_t mem [64];

  assign data_o = mem[addr_i[7:2]];

endmodule

// Data memory of 256 words written when an access completes
module dmem_model
  import isa_pkg::*;
(
  input  logic  clock,
  input  word_t addr_i,
  input  logic  wr_i,
  input  word_t wr_data_i,
  input  logic  waitrequest_i,
  output word_t rd_data_o
);

  word_t mem [256];

  assign rd_data_o = mem[addr_i[9:2]];

  always @(posedge clock) begin
    if (wr_i && !waitrequest_i) begin
      mem[addr_i[9:2]] <= wr_data_i;
    end
  end

endmodule

// Register file with write-before-read bypass and r0 reading as zero
module rfile_model
  import isa_pkg::*;
(
  input  logic     clock,
  input  reg_idx_t rd_addr1_i,
  input  reg_idx_t rd_addr2_i,
  output word_t    rd_data1_o,
  output word_t    rd_data2_o,
  input  reg_idx_t wr_addr_i,
  input  logic     wr_en_i,
  input  word_t    wr_data_i
);

  word_t regs [32];

  assign rd_data1_o = (rd_addr1_i == 5'd0) ? '0 :
                      (wr_en_i && wr_addr_i == rd_addr1_i) ? wr_data_i : regs[rd_addr1_i];
  assign rd_data2_o = (rd_addr2_i == 5'd0) ? '0 :
                      (wr_en_i && wr_addr_i == rd_addr2_i) ? wr_data_i : regs[rd_addr2_i];

  always @(posedge clock) begin
    if (wr_en_i && wr_addr_i != 5'd0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

// Random wait states for both caches on each falling edge
module wait_gen #(
  parameter logic [31:0] seed = 32'h0
)(
  input  logic clock,
  input  logic enable_i,
  output logic iwait_o,
  output logic dwait_o
);

  initial begin
    iwait_o = 1'b0;
    dwait_o = 1'b0;
    void'($urandom(seed));
    forever begin
      @(negedge clock);
      iwait_o = ($urandom % 4 == 0) && enable_i;
      dwait_o = ($urandom % 3 == 0) && enable_i;
    end
  end

endmodule

// ==== testbench/tb_pipeline.sv ====
`timescale 1ns/100ps

module tb_pipeline
  import isa_pkg::*;
();

  localparam word_t reset_pc  = 32'h0000_0040;
  localparam int    num_tests = 9;

  logic        clock;
  logic        arst_n;
  logic        wait_en;
  word_t       icache_addr;
  logic        icache_rd;
  word_t       icache_data;
  logic        iwait;
  reg_idx_t    rf_rd_addr1;
  reg_idx_t    rf_rd_addr2;
  word_t       rf_rd_data1;
  word_t       rf_rd_data2;
  word_t       dcache_addr;
  logic        dcache_rd;
  logic        dcache_wr;
  word_t       dcache_wr_data;
  logic [3:0]  dcache_wr_be;
  word_t       dcache_data;
  logic        dwait;
  reg_idx_t    rf_wr_addr;
  logic        rf_wr_en;
  word_t       rf_wr_data;

  word_t       prog [$];
  logic [63:0] exp_reg_q [$];
  logic [63:0] exp_store_q [$];
  word_t       exp_load_q [$];
  string       test_name;
  int          error_count = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          total_insts;

  int    test_ids [num_tests]   = '{1, 2, 3, 4, 5, 2, 3, 4, 5};
  string test_names [num_tests] = '{"reset", "alu", "forwarding", "load_store", "branches",
                                    "alu_waits", "forwarding_waits", "load_store_waits",
                                    "branches_waits"};

  pipeline #(
    .addr_width           (32),
    .reset_pc             (reset_pc)
  ) pipeline_i (
    .clock                (clock),
    .arst_n_i             (arst_n),
    .icache_addr_o        (icache_addr),
    .icache_rd_o          (icache_rd),
    .icache_data_i        (icache_data),
    .icache_waitrequest_i (iwait),
    .rfile_rd_addr1_o     (rf_rd_addr1),
    .rfile_rd_addr2_o     (rf_rd_addr2),
    .rfile_rd_data1_i     (rf_rd_data1),
    .rfile_rd_data2_i     (rf_rd_data2),
    .dcache_addr_o        (dcache_addr),
    .dcache_rd_o          (dcache_rd),
    .dcache_wr_o          (dcache_wr),
    .dcache_wr_data_o     (dcache_wr_data),
    .dcache_wr_be_o       (dcache_wr_be),
    .dcache_data_i        (dcache_data),
    .dcache_waitrequest_i (dwait),
    .rfile_wr_addr1_o     (rf_wr_addr),
    .rfile_wr_enable1_o   (rf_wr_en),
    .rfile_wr_data1_o     (rf_wr_data)
  );

  imem_model imem_i (
    .addr_i (icache_addr),
    .data_o (icache_data)
  );

  dmem_model dmem_i (
    .clock         (clock),
    .addr_i        (dcache_addr),
    .wr_i          (dcache_wr),
    .wr_data_i     (dcache_wr_data),
    .waitrequest_i (dwait),
    .rd_data_o     (dcache_data)
  );

  rfile_model rfile_i (
    .clock      (clock),
    .rd_addr1_i (rf_rd_addr1),
    .rd_addr2_i (rf_rd_addr2),
    .rd_data1_o (rf_rd_data1),
    .rd_data2_o (rf_rd_data2),
    .wr_addr_i  (rf_wr_addr),
    .wr_en_i    (rf_wr_en),
    .wr_data_i  (rf_wr_data)
  );

  wait_gen #(
    .seed (32'h536df300)
  ) waits_i (
    .clock    (clock),
    .enable_i (wait_en),
    .iwait_o  (iwait),
    .dwait_o  (dwait)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic word_t rtype(logic [5:0] fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {op_rtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t itype(logic [5:0] op, reg_idx_t rt, reg_idx_t rs, imm16_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t fill_word(word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  function automatic word_t reg_init(int idx);
    return word_t'(idx) * 32'h1357_9bdf;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    error_count++;
  endtask

  task automatic build_program(input int id);
    prog.delete();
    case (id)
      2: begin
        prog.push_back(rtype(fn_addu, 11, 1, 2));
        prog.push_back(rtype(fn_subu, 12, 3, 4));
        prog.push_back(rtype(fn_and, 13, 5, 6));
        prog.push_back(rtype(fn_or, 14, 7, 8));
        prog.push_back(rtype(fn_xor, 15, 9, 1));
        prog.push_back(rtype(fn_slt, 16, 7, 2));
        prog.push_back(rtype(fn_sltu, 17, 7, 2));
        prog.push_back(itype(op_addiu, 18, 3, 16'hfffb));
        prog.push_back(itype(op_ori, 19, 4, 16'h8001));
        prog.push_back(rtype(fn_addu, 0, 1, 2));
      end
      3: begin
        prog.push_back(itype(op_addiu, 1, 0, 16'd100));
        prog.push_back(rtype(fn_addu, 2, 1, 1));
        prog.push_back(rtype(fn_subu, 3, 2, 1));
        prog.push_back(rtype(fn_xor, 4, 3, 2));
        prog.push_back(rtype(fn_or, 5, 1, 4));
        prog.push_back(itype(op_addiu, 5, 5, 16'd7));
        prog.push_back(rtype(fn_addu, 6, 5, 5));
        prog.push_back(rtype(fn_sltu, 7, 6, 3));
      end
      4: begin
        prog.push_back(itype(op_ori, 10, 0, 16'h0100));
        prog.push_back(itype(op_sw, 1, 10, 16'd0));
        prog.push_back(itype(op_lw, 2, 10, 16'd0));
        prog.push_back(rtype(fn_addu, 3, 2, 2));
        prog.push_back(itype(op_sw, 3, 10, 16'd8));
        prog.push_back(itype(op_lw, 4, 10, 16'd8));
        prog.push_back(itype(op_lw, 5, 10, 16'd12));
        prog.push_back(rtype(fn_subu, 6, 5, 4));
        prog.push_back(itype(op_sw, 6, 10, 16'hfffc));
      end
      5: begin
        prog.push_back(itype(op_addiu, 1, 0, 16'd5));
        prog.push_back(itype(op_addiu, 2, 0, 16'd5));
        prog.push_back(itype(op_beq, 2, 1, 16'd2));
        prog.push_back(itype(op_addiu, 3, 0, 16'd1));
        prog.push_back(itype(op_addiu, 4, 0, 16'd2));
        prog.push_back(itype(op_bne, 2, 1, 16'd1));
        prog.push_back(itype(op_addiu, 5, 0, 16'd3));
        prog.push_back(itype(op_addiu, 6, 1, 16'd1));
        prog.push_back(itype(op_bne, 1, 6, 16'd2));
        prog.push_back(itype(op_addiu, 7, 0, 16'd9));
        prog.push_back(itype(op_addiu, 8, 0, 16'd9));
        prog.push_back(itype(op_beq, 1, 6, 16'd1));
        prog.push_back(itype(op_addiu, 9, 0, 16'd4));
      end
      default: ;
    endcase
    // Branch to self ends every program
    prog.push_back(itype(op_beq, 0, 0, 16'hffff));
  endtask

  task automatic load_models();
    for (int i = 0; i < 64; i++) begin
      imem_i.mem[i] = nop_word;
    end
    foreach (prog[k]) begin
      imem_i.mem[int'(reset_pc[7:2]) + k] = prog[k];
    end
    for (int i = 0; i < 256; i++) begin
      dmem_i.mem[i] = fill_word(word_t'(i) << 2);
    end
    for (int i = 0; i < 32; i++) begin
      rfile_i.regs[i] = reg_init(i);
    end
  endtask

  // In-order reference execution of prog
  task automatic run_golden();
    word_t    regs [32];
    word_t    dmem [256];
    word_t    pc;
    word_t    next_pc;
    word_t    inst;
    word_t    a;
    word_t    b;
    word_t    simm;
    word_t    addr;
    word_t    res;
    reg_idx_t dst;
    logic     halted;
    int       steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = reg_init(i);
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fill_word(word_t'(i) << 2);
    end
    exp_reg_q.delete();
    exp_store_q.delete();
    exp_load_q.delete();
    pc     = reset_pc;
    halted = 1'b0;
    steps  = 0;
    while (!halted && steps < 200) begin
      inst    = prog[(pc - reset_pc) >> 2];
      a       = regs[inst[25:21]];
      b       = regs[inst[20:16]];
      simm    = {{16{inst[15]}}, inst[15:0]};
      dst     = 5'd0;
      res     = '0;
      next_pc = pc + 32'd4;
      case (inst[31:26])
        op_rtype: begin
          dst = inst[15:11];
          case (inst[5:0])
            fn_addu: res = a + b;
            fn_subu: res = a - b;
            fn_and:  res = a & b;
            fn_or:   res = a | b;
            fn_xor:  res = a ^ b;
            fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
            fn_sltu: res = {31'd0, a < b};
            default: dst = 5'd0;
          endcase
        end
        op_addiu: begin
          dst = inst[20:16];
          res = a + simm;
        end
        op_ori: begin
          dst = inst[20:16];
          res = a | {16'h0000, inst[15:0]};
        end
        op_lw: begin
          addr = a + simm;
          exp_load_q.push_back(addr);
          dst = inst[20:16];
          res = dmem[addr[9:2]];
        end
        op_sw: begin
          addr = a + simm;
          exp_store_q.push_back({addr, b});
          dmem[addr[9:2]] = b;
        end
        op_beq: begin
          if (a == b) next_pc = pc + 32'd4 + (simm << 2);
        end
        op_bne: begin
          if (a != b) next_pc = pc + 32'd4 + (simm << 2);
        end
        default: ;
      endcase
      if (dst != 5'd0) begin
        regs[dst] = res;
        exp_reg_q.push_back({27'd0, dst, res});
      end
      halted = (next_pc == pc);
      pc     = next_pc;
      steps++;
    end
  endtask

  task automatic check_reg_write();
    logic [63:0] exp;
    assert (rf_wr_addr != 5'd0)
      else note_error($sformatf("%s: register 0 was written", test_name));
    assert (exp_reg_q.size() != 0)
      else note_error($sformatf("%s: register r%0d written, but no write was due",
                                test_name, rf_wr_addr));
    if (exp_reg_q.size() != 0) begin
      exp = exp_reg_q.pop_front();
      assert (rf_wr_addr == exp[36:32] && rf_wr_data == exp[31:0])
        else note_error($sformatf("Error %s: register write expected r%0d=%h, actual r%0d=%h",
                                  test_name, exp[36:32], exp[31:0], rf_wr_addr, rf_wr_data));
    end
  endtask

  task automatic check_store();
    logic [63:0] exp;
    assert (dcache_wr_be == 4'hf)
      else note_error($sformatf("Error %s: byte enable expected f, actual %h",
                                test_name, dcache_wr_be));
    assert (exp_store_q.size() != 0)
      else note_error($sformatf("%s: store to %h, but no store was due", test_name, dcache_addr));
    if (exp_store_q.size() != 0) begin
      exp = exp_store_q.pop_front();
      assert (dcache_addr == exp[63:32] && dcache_wr_data == exp[31:0])
        else note_error($sformatf("Error %s: store expected [%h]=%h, actual [%h]=%h", test_name,
                                  exp[63:32], exp[31:0], dcache_addr, dcache_wr_data));
    end
  endtask

  task automatic check_load();
    word_t exp;
    assert (exp_load_q.size() != 0)
      else note_error($sformatf("%s: load from %h, but no load was due", test_name, dcache_addr));
    if (exp_load_q.size() != 0) begin
      exp = exp_load_q.pop_front();
      assert (dcache_addr == exp)
        else note_error($sformatf("Error %s: load address expected %h, actual %h",
                                  test_name, exp, dcache_addr));
    end
  endtask

  always @(posedge clock) begin
    if (!arst_n) begin
      assert (!dcache_rd && !dcache_wr && !rf_wr_en)
        else note_error($sformatf("%s: a strobe is high during reset", test_name));
    end else begin
      if (rf_wr_en) check_reg_write();
      if (dcache_wr && !dwait) check_store();
      if (dcache_rd && !dwait) check_load();
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  task automatic run_test(input string name, input int id, input bit waits);
    int errors_before;
    arst_n        = 1'b0;
    wait_en       = waits;
    test_name     = name;
    errors_before = error_count;
    build_program(id);
    load_models();
    run_golden();
    repeat (8) @(negedge clock);
    arst_n = 1'b1;
    assert (icache_addr == reset_pc)
      else note_error($sformatf("Error %s: first fetch address expected %h, actual %h",
                                name, reset_pc, icache_addr));
    assert (icache_rd)
      else note_error($sformatf("%s: no instruction fetch requested after reset", name));
    while (exp_reg_q.size() != 0 || exp_store_q.size() != 0 || exp_load_q.size() != 0) begin
      @(negedge clock);
    end
    // Stray writes from squashed instructions would show up here
    repeat (16) @(negedge clock);
    if (error_count == errors_before) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: FAIL with %0d errors", name, error_count - errors_before);
    end
  endtask

  initial begin
    arst_n      = 1'b0;
    wait_en     = 1'b0;
    total_insts = 0;
    foreach (test_ids[t]) begin
      build_program(test_ids[t]);
      total_insts += prog.size();
    end
    cycle_limit = 40 * total_insts;
    foreach (test_ids[t]) begin
      run_test(test_names[t], test_ids[t], t >= 5);
    end
    $display("summary: %0d run, %0d passed, %0d failed, %0d errors",
             num_tests, pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/pipe_ifaces.sv
src/ifetch.sv
src/idec.sv
src/ex.sv
src/mem_stage.sv
src/pipeline.sv
testbench/tb_models.sv
testbench/tb_pipeline.sv
